/* compile.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_d0.sv
source/lsu_d1.sv
source/dcache_array.sv
source/miss_fill_unit.sv
source/lsu_dcache.sv
tests/lsu_dcache_checker.sv
tests/lsu_dcache_monitor.sv
tests/lsu_dcache_tb.sv

/* Bender.yml */
package:
  name: lsu_dcache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_d0.sv
      - source/lsu_d1.sv
      - source/dcache_array.sv
      - source/miss_fill_unit.sv
      - source/lsu_dcache.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/lsu_dcache_checker.sv
      - tests/lsu_dcache_monitor.sv
      - tests/lsu_dcache_tb.sv

/* tests/lsu_dcache_tb.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsu_dcache_tb;

    import lsu_pkg::*;

    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 100;

    logic                            clk;
    logic                            n_rst;
    logic                            i_flush;
    logic                            i_valid;
    lsu_req_t                        i_req;
    logic                            o_resp_valid;
    lsu_resp_t                       o_resp;
    logic                            o_store_valid;
    lsu_store_t                      o_store;
    logic                            o_mem_req_valid;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] o_mem_req_line_addr;
    logic                            i_mem_fill_valid;
    lsu_fill_t                       i_mem_fill;

    int mismatches;
    int other_errors;
    int outstanding;
    int tb_errors;
    int assert_fails;
    int drain_cycles;

    logic [`LSU_DATA_WIDTH-1:0]      mem [int unsigned]; // memory behind the cache.
    logic                            resp_pending;
    int                              resp_delay;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] resp_line;

    // 6 lines with two tags on each of sets 1, 5 and 9
    logic [`LSU_LINE_ADDR_WIDTH-1:0] line_pool [6] = '{
        {23'h000012, 4'd1}, {23'h0001a3, 4'd1},
        {23'h000012, 4'd5}, {23'h0004c0, 4'd5},
        {23'h000077, 4'd9}, {23'h0001a3, 4'd9}
    };

    lsu_dcache lsu_dcache_inst (.*);

    lsu_dcache_monitor lsu_dcache_monitor_inst (
        .clk                 (clk),
        .n_rst               (n_rst),
        .i_flush             (i_flush),
        .i_valid             (i_valid),
        .i_req               (i_req),
        .i_resp_valid        (o_resp_valid),
        .i_resp              (o_resp),
        .i_store_valid       (o_store_valid),
        .i_store             (o_store),
        .i_mem_req_valid     (o_mem_req_valid),
        .i_mem_req_line_addr (o_mem_req_line_addr),
        .i_mem_fill_valid    (i_mem_fill_valid),
        .o_mismatches        (mismatches),
        .o_other_errors      (other_errors),
        .o_outstanding       (outstanding)
    );

    bind lsu_dcache lsu_dcache_checker lsu_dcache_checker_inst (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_resp_valid     (o_resp_valid),
        .i_store_valid    (o_store_valid),
        .i_mem_req_valid  (o_mem_req_valid),
        .i_mem_fill_valid (i_mem_fill_valid)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        int unsigned idx;
        idx = addr[31:2];
        if (mem.exists(idx)) begin
            return mem[idx];
        end
        return idx * 3 + 7;
    endfunction

    always #50 clk = ~clk;

    // memory responder gives one fill per request after 3 to 12 cycles
    always @(posedge clk) begin
        if (n_rst && o_store_valid) begin
            mem[o_store.addr[31:2]] = o_store.data;
        end
        if (n_rst && o_mem_req_valid) begin
            resp_pending = 1'b1;
            resp_line    = o_mem_req_line_addr;
            resp_delay   = 3 + ($urandom % 10);
        end
        #1;
        i_mem_fill_valid = 1'b0;
        if (resp_pending) begin
            if (resp_delay <= 1) begin
                i_mem_fill.line_addr = resp_line;
                for (int w = 0; w < 8; w++) begin
                    i_mem_fill.data[w*32 +: 32] = mem_word({resp_line, w[2:0], 2'b00});
                end
                i_mem_fill_valid = 1'b1;
                resp_pending     = 1'b0;
            end else begin
                resp_delay--;
            end
        end
    end

    initial begin
        clk              = 1'b0;
        n_rst            = 1'b0;
        i_flush          = 1'b0;
        i_valid          = 1'b0;
        i_req            = '0;
        i_mem_fill_valid = 1'b0;
        i_mem_fill       = '0;
        resp_pending     = 1'b0;
        resp_delay       = 0;
        resp_line        = '0;
        tb_errors        = 0;
        assert_fails     = 0;
        void'($urandom(91));

        repeat (8) @(posedge clk);
        #1 n_rst = 1'b1;

        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            #1;
            i_valid    = (($urandom % 4) != 0);
            i_flush    = (($urandom % 32) == 0); // rare.
            i_req.func = lsu_func_t'($urandom % 2);
            i_req.tag  = $urandom;
            i_req.addr = {line_pool[$urandom % 6], 3'($urandom % 8), 2'b00};
            i_req.data = $urandom;
        end
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        i_flush = 1'b0;

        drain_cycles = 0;
        @(negedge clk);
        while ((outstanding != 0 || resp_pending) && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            drain_cycles++;
        end
        if (drain_cycles >= DRAIN_LIMIT) begin
            $display("Error: timeout waiting for responses and fills to drain");
            tb_errors++;
        end
        repeat (2) @(posedge clk);

        assert_fails = lsu_dcache_inst.lsu_dcache_checker_inst.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d testbench, %0d assertion",
                 mismatches, other_errors, tb_errors, assert_fails);
        if (mismatches + other_errors + tb_errors + assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tests/lsu_dcache_monitor.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsu_dcache_monitor (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_flush,
    input  logic                            i_valid,
    input  lsu_pkg::lsu_req_t               i_req,
    input  logic                            i_resp_valid,
    input  lsu_pkg::lsu_resp_t              i_resp,
    input  logic                            i_store_valid,
    input  lsu_pkg::lsu_store_t             i_store,
    input  logic                            i_mem_req_valid,
    input  logic [`LSU_LINE_ADDR_WIDTH-1:0] i_mem_req_line_addr,
    input  logic                            i_mem_fill_valid,
    output int                              o_mismatches,
    output int                              o_other_errors,
    output int                              o_outstanding
);

    import lsu_pkg::*;

    logic [`LSU_CTAG_WIDTH-1:0]      shadow_tag [16];
    logic [15:0]                     shadow_valid;
    logic [`LSU_DATA_WIDTH-1:0]      mem [int unsigned]; // words written by stores.
    logic                            busy;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] pend_line;
    logic                            prev_fill;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] prev_fill_line;
    logic                            d0_live;   // request sitting in stage 0.
    lsu_req_t                        d0_req;
    logic                            have_exp;  // response due at the next edge.
    lsu_resp_t                       exp_resp;
    logic                            exp_st;
    lsu_store_t                      exp_store;
    logic                            exp_mreq;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] exp_mreq_line;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        int unsigned idx;
        idx = addr[31:2];
        if (mem.exists(idx)) begin
            return mem[idx];
        end
        return idx * 3 + 7;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
        o_mismatches++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        o_other_errors++;
    endtask

    initial begin
        o_mismatches   = 0;
        o_other_errors = 0;
        o_outstanding  = 0;
        d0_live        = 1'b0;
        have_exp       = 1'b0;
        exp_mreq       = 1'b0;
        busy           = 1'b0;
        prev_fill      = 1'b0;
        shadow_valid   = '0;
    end

    always @(posedge clk) begin
        logic [`LSU_LINE_ADDR_WIDTH-1:0] line;
        logic                            replay;
        logic                            hit;
        logic                            is_store;
        logic                            busy_before;
        logic                            alloc;
        if (~n_rst) begin
            d0_live      = 1'b0;
            have_exp     = 1'b0;
            exp_mreq     = 1'b0;
            busy         = 1'b0;
            prev_fill    = 1'b0;
            shadow_valid = '0;
        end else begin
            // compare what the DUT registered at the previous edge
            if (have_exp) begin
                if (!i_resp_valid) begin
                    report_error("expected response did not appear");
                end else begin
                    if (i_resp.tag !== exp_resp.tag)
                        report_mismatch("o_resp.tag", exp_resp.tag, i_resp.tag);
                    if (i_resp.status !== exp_resp.status)
                        report_mismatch("o_resp.status", exp_resp.status, i_resp.status);
                    if (i_resp.data !== exp_resp.data)
                        report_mismatch("o_resp.data", exp_resp.data, i_resp.data);
                end
                if (i_store_valid !== exp_st) begin
                    report_mismatch("o_store_valid", exp_st, i_store_valid);
                end else if (exp_st && (i_store !== exp_store)) begin
                    report_mismatch("o_store", exp_store, i_store);
                end
            end else begin
                if (i_resp_valid) report_error("response without a live request");
                if (i_store_valid) report_error("store-through without a live request");
            end
            if (i_mem_req_valid !== exp_mreq) begin
                report_mismatch("o_mem_req_valid", exp_mreq, i_mem_req_valid);
            end else if (exp_mreq && (i_mem_req_line_addr !== exp_mreq_line)) begin
                report_mismatch("o_mem_req_line_addr", exp_mreq_line, i_mem_req_line_addr);
            end

            if (have_exp && exp_st) begin
                mem[exp_store.addr[31:2]] = exp_store.data;
            end

            // stage 1 of the request that entered at the previous edge
            busy_before = busy;
            alloc       = 1'b0;
            have_exp    = 1'b0;
            exp_mreq    = 1'b0;
            if (d0_live && !i_flush) begin
                line     = d0_req.addr[31:5];
                is_store = (d0_req.func == LSU_STORE);
                replay   = (prev_fill && (prev_fill_line == line)) ||
                           (i_mem_fill_valid && busy_before && (pend_line == line));
                hit      = shadow_valid[line[3:0]] && (shadow_tag[line[3:0]] == line[26:4]);
                exp_resp.tag = d0_req.tag;
                if (replay) begin
                    exp_resp.status = ST_FILL_REPLAY;
                end else if (hit) begin
                    exp_resp.status = ST_HIT;
                end else begin
                    exp_resp.status = ST_MISS;
                end
                if (is_store) begin
                    exp_resp.data = d0_req.data;
                end else if (exp_resp.status == ST_HIT) begin
                    exp_resp.data = mem_word(d0_req.addr);
                end else begin
                    exp_resp.data = '0;
                end
                exp_st         = is_store && (exp_resp.status == ST_HIT);
                exp_store.addr = d0_req.addr;
                exp_store.data = d0_req.data;
                have_exp       = 1'b1;
                alloc          = (exp_resp.status == ST_MISS) && !busy_before;
                exp_mreq       = alloc;
                exp_mreq_line  = line;
            end

            prev_fill      = i_mem_fill_valid && busy_before;
            prev_fill_line = pend_line;
            if (i_mem_fill_valid) begin
                if (!busy_before) begin
                    report_error("memory fill arrived with no miss pending");
                end else begin
                    shadow_valid[pend_line[3:0]] = 1'b1;
                    shadow_tag[pend_line[3:0]]   = pend_line[26:4];
                    busy = 1'b0;
                end
            end
            if (alloc) begin
                busy      = 1'b1;
                pend_line = line;
            end

            d0_live = i_valid && !i_flush;
            d0_req  = i_req;
        end
        o_outstanding = int'(d0_live) + int'(have_exp);
    end

endmodule

/* tests/lsu_dcache_checker.sv */
`timescale 1ns/1ps

module lsu_dcache_checker (
    input logic clk,
    input logic n_rst,
    input logic i_resp_valid,
    input logic i_store_valid,
    input logic i_mem_req_valid,
    input logic i_mem_fill_valid
);

    logic req_open_q; // a memory request waits for its fill.
    int   fail_count = 0;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            req_open_q <= 1'b0;
        end else if (i_mem_req_valid) begin
            req_open_q <= 1'b1;
        end else if (i_mem_fill_valid) begin
            req_open_q <= 1'b0;
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(n_rst) |=> (~i_resp_valid & ~i_store_valid & ~i_mem_req_valid))
        else begin
            $error("outputs active in the first cycle after reset");
            fail_count++;
        end

    store_with_resp: assert property (@(posedge clk) disable iff (~n_rst)
        i_store_valid |-> i_resp_valid)
        else begin
            $error("store-through without a response");
            fail_count++;
        end

    one_miss_only: assert property (@(posedge clk) disable iff (~n_rst)
        i_mem_req_valid |-> ~req_open_q)
        else begin
            $error("memory request issued while one is unanswered");
            fail_count++;
        end

endmodule

/* source/lsu_dcache.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsu_dcache (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,

    input  logic                            i_valid,
    input  lsu_pkg::lsu_req_t               i_req,

    output logic                            o_resp_valid,
    output lsu_pkg::lsu_resp_t              o_resp,

    output logic                            o_store_valid,
    output lsu_pkg::lsu_store_t             o_store,

    output logic                            o_mem_req_valid,
    output logic [`LSU_LINE_ADDR_WIDTH-1:0] o_mem_req_line_addr,
    input  logic                            i_mem_fill_valid,
    input  lsu_pkg::lsu_fill_t              i_mem_fill
);

    import lsu_pkg::*;

    logic                            d0_valid;
    logic                            d0_fill_replay;
    lsu_req_t                        d0_req;

    logic [`LSU_CTAG_WIDTH-1:0]      rd_tag;
    logic                            rd_valid;
    logic [`LSU_LINE_WIDTH-1:0]      rd_line;

    logic                            wr_en;
    logic [`LSU_ADDR_WIDTH-1:0]      wr_addr;
    logic [`LSU_DATA_WIDTH-1:0]      wr_data;

    logic                            miss_valid;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] miss_line_addr;

    logic                            fill_en;
    lsu_fill_t                       fill;

    lsu_d0 lsu_d0_inst (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_fill_en        (fill_en),
        .i_fill_line_addr (fill.line_addr),
        .i_valid          (i_valid),
        .i_req            (i_req),
        .o_valid          (d0_valid),
        .o_fill_replay    (d0_fill_replay),
        .o_req            (d0_req)
    );

    // read indexed straight from the incoming request to line up with d0
    dcache_array dcache_array_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_index (i_req.addr[`LSU_OFFSET_WIDTH +: `LSU_INDEX_WIDTH]),
        .o_rd_tag   (rd_tag),
        .o_rd_valid (rd_valid),
        .o_rd_line  (rd_line),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .i_fill_en  (fill_en),
        .i_fill     (fill)
    );

    lsu_d1 lsu_d1_inst (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_valid          (d0_valid),
        .i_fill_replay    (d0_fill_replay),
        .i_req            (d0_req),
        .i_rd_tag         (rd_tag),
        .i_rd_valid       (rd_valid),
        .i_rd_line        (rd_line),
        .o_wr_en          (wr_en),
        .o_wr_addr        (wr_addr),
        .o_wr_data        (wr_data),
        .o_miss_valid     (miss_valid),
        .o_miss_line_addr (miss_line_addr),
        .o_resp_valid     (o_resp_valid),
        .o_resp           (o_resp),
        .o_store_valid    (o_store_valid),
        .o_store          (o_store)
    );

    miss_fill_unit miss_fill_unit_inst (
        .clk                 (clk),
        .n_rst               (n_rst),
        .i_miss_valid        (miss_valid),
        .i_miss_line_addr    (miss_line_addr),
        .o_mem_req_valid     (o_mem_req_valid),
        .o_mem_req_line_addr (o_mem_req_line_addr),
        .i_mem_fill_valid    (i_mem_fill_valid),
        .i_mem_fill          (i_mem_fill),
        .o_fill_en           (fill_en),
        .o_fill              (fill)
    );

endmodule

/* source/miss_fill_unit.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module miss_fill_unit (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_miss_valid,
    input  logic [`LSU_LINE_ADDR_WIDTH-1:0] i_miss_line_addr,

    output logic                            o_mem_req_valid,
    output logic [`LSU_LINE_ADDR_WIDTH-1:0] o_mem_req_line_addr,

    input  logic                            i_mem_fill_valid,
    input  lsu_pkg::lsu_fill_t              i_mem_fill,

    output logic                            o_fill_en,
    output lsu_pkg::lsu_fill_t              o_fill
);

    logic                            busy_q;
    logic [`LSU_LINE_ADDR_WIDTH-1:0] line_addr_q; // the one pending miss.
    logic                            alloc;

    // a miss while busy is dropped; the requester already saw ST_MISS
    assign alloc = i_miss_valid & ~busy_q;

    always_ff @(posedge clk) begin
        if (alloc) begin
            line_addr_q <= i_miss_line_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            busy_q          <= 1'b0;
            o_mem_req_valid <= 1'b0;
        end else begin
            o_mem_req_valid <= alloc; // single cycle pulse.
            if (alloc) begin
                busy_q <= 1'b1;
            end else if (i_mem_fill_valid) begin
                busy_q <= 1'b0; // freed on the fill edge.
            end
        end
    end

    assign o_mem_req_line_addr = line_addr_q;

    // stray fills while idle never reach the array
    assign o_fill_en        = i_mem_fill_valid & busy_q;
    assign o_fill.line_addr = line_addr_q; // stamped with the held address.
    assign o_fill.data      = i_mem_fill.data;

endmodule

/* source/dcache_array.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module dcache_array (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic [`LSU_INDEX_WIDTH-1:0]     i_rd_index,
    output logic [`LSU_CTAG_WIDTH-1:0]      o_rd_tag,
    output logic                            o_rd_valid,
    output logic [`LSU_LINE_WIDTH-1:0]      o_rd_line,

    input  logic                            i_wr_en,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_wr_addr,
    input  logic [`LSU_DATA_WIDTH-1:0]      i_wr_data,

    input  logic                            i_fill_en,
    input  lsu_pkg::lsu_fill_t              i_fill
);

    localparam int unsigned NUM_SETS = 1 << `LSU_INDEX_WIDTH;

    logic [`LSU_CTAG_WIDTH-1:0]     tag_q  [NUM_SETS];
    logic [`LSU_LINE_WIDTH-1:0]     line_q [NUM_SETS];
    logic [NUM_SETS-1:0]            valid_q;

    logic [`LSU_INDEX_WIDTH-1:0]    wr_index;
    logic [`LSU_WORD_SEL_WIDTH-1:0] wr_word;
    logic [`LSU_LINE_WIDTH-1:0]     wr_line;   // line with the word merged in.
    logic [`LSU_INDEX_WIDTH-1:0]    fill_index;
    logic [`LSU_CTAG_WIDTH-1:0]     fill_ctag;

    logic [`LSU_CTAG_WIDTH-1:0]     rd_tag_next;
    logic                           rd_valid_next;
    logic [`LSU_LINE_WIDTH-1:0]     rd_line_next;

    assign wr_index   = i_wr_addr[`LSU_OFFSET_WIDTH +: `LSU_INDEX_WIDTH];
    assign wr_word    = i_wr_addr[`LSU_OFFSET_WIDTH-1:2];
    assign fill_index = i_fill.line_addr[`LSU_INDEX_WIDTH-1:0];
    assign fill_ctag  = i_fill.line_addr[`LSU_LINE_ADDR_WIDTH-1:`LSU_INDEX_WIDTH];

    always_comb begin
        wr_line = line_q[wr_index];
        wr_line[wr_word*`LSU_DATA_WIDTH +: `LSU_DATA_WIDTH] = i_wr_data;
    end

    // forward this edge's write so the read never returns stale contents
    always_comb begin
        rd_tag_next   = tag_q[i_rd_index];
        rd_valid_next = valid_q[i_rd_index];
        rd_line_next  = line_q[i_rd_index];
        if (i_fill_en && (fill_index == i_rd_index)) begin
            rd_tag_next   = fill_ctag;
            rd_valid_next = 1'b1;
            rd_line_next  = i_fill.data;
        end else if (i_wr_en && (wr_index == i_rd_index)) begin
            rd_line_next  = wr_line;
        end
    end

    // fill is written last, so it wins on a shared set
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_q[wr_index] <= wr_line;
        end
        if (i_fill_en) begin
            line_q[fill_index] <= i_fill.data;
            tag_q[fill_index]  <= fill_ctag;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_q <= '0;
        end else if (i_fill_en) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        o_rd_tag  <= rd_tag_next;
        o_rd_line <= rd_line_next;
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= rd_valid_next;
        end
    end

endmodule

/* source/lsu_d1.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsu_d1 (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,

    input  logic                            i_valid,
    input  logic                            i_fill_replay,
    input  lsu_pkg::lsu_req_t               i_req,

    input  logic [`LSU_CTAG_WIDTH-1:0]      i_rd_tag,
    input  logic                            i_rd_valid,
    input  logic [`LSU_LINE_WIDTH-1:0]      i_rd_line,

    output logic                            o_wr_en,
    output logic [`LSU_ADDR_WIDTH-1:0]      o_wr_addr,
    output logic [`LSU_DATA_WIDTH-1:0]      o_wr_data,

    output logic                            o_miss_valid,
    output logic [`LSU_LINE_ADDR_WIDTH-1:0] o_miss_line_addr,

    output logic                            o_resp_valid,
    output lsu_pkg::lsu_resp_t              o_resp,

    output logic                            o_store_valid,
    output lsu_pkg::lsu_store_t             o_store
);

    import lsu_pkg::*;

    logic                           live;
    logic                           is_store;
    logic                           tag_hit;
    logic [`LSU_CTAG_WIDTH-1:0]     req_ctag;
    logic [`LSU_WORD_SEL_WIDTH-1:0] word_sel;
    logic [`LSU_DATA_WIDTH-1:0]     rd_word;
    lsu_status_t                    status;
    lsu_resp_t                      resp_next;

    assign live     = i_valid & ~i_flush;
    assign is_store = (i_req.func == LSU_STORE);
    assign req_ctag = i_req.addr[`LSU_ADDR_WIDTH-1 -: `LSU_CTAG_WIDTH];
    assign word_sel = i_req.addr[`LSU_OFFSET_WIDTH-1:2]; // addr bits 4 to 2.
    assign rd_word  = i_rd_line[word_sel*`LSU_DATA_WIDTH +: `LSU_DATA_WIDTH];
    assign tag_hit  = i_rd_valid & (i_rd_tag == req_ctag);

    // replay outranks a hit
    always_comb begin
        if (i_fill_replay) begin
            status = ST_FILL_REPLAY;
        end else if (tag_hit) begin
            status = ST_HIT;
        end else begin
            status = ST_MISS;
        end
    end

    always_comb begin
        resp_next.tag    = i_req.tag;
        resp_next.status = status;
        if (is_store) begin
            resp_next.data = i_req.data;
        end else if (status == ST_HIT) begin
            resp_next.data = rd_word;
        end else begin
            resp_next.data = '0;
        end
    end

    assign o_wr_en   = live & is_store & (status == ST_HIT); // lands this edge.
    assign o_wr_addr = i_req.addr;
    assign o_wr_data = i_req.data;

    assign o_miss_valid     = live & (status == ST_MISS);
    assign o_miss_line_addr = i_req.addr[`LSU_ADDR_WIDTH-1:`LSU_OFFSET_WIDTH];

    always_ff @(posedge clk) begin
        o_resp       <= resp_next;
        o_store.addr <= i_req.addr;
        o_store.data <= i_req.data;
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_resp_valid  <= 1'b0;
            o_store_valid <= 1'b0;
        end else begin
            o_resp_valid  <= live;
            o_store_valid <= o_wr_en; // store-through with the response.
        end
    end

endmodule

/* source/lsu_d0.sv */
`timescale 1ns/1ps

`include "lsu_defs.svh"

module lsu_d0 (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,

    input  logic                            i_fill_en,
    input  logic [`LSU_LINE_ADDR_WIDTH-1:0] i_fill_line_addr,

    input  logic                            i_valid,
    input  lsu_pkg::lsu_req_t               i_req,

    output logic                            o_valid,
    output logic                            o_fill_replay,
    output lsu_pkg::lsu_req_t               o_req
);

    logic replay_q;   // fill hit the line on entry.
    logic replay_now; // fill hits the line while held here.

    // a fill on the request's line races the tag compare in d1
    assign replay_now = i_fill_en &
        (i_fill_line_addr == o_req.addr[`LSU_ADDR_WIDTH-1:`LSU_OFFSET_WIDTH]);

    assign o_fill_replay = replay_q | replay_now;

    always_ff @(posedge clk) begin
        replay_q <= i_fill_en &
            (i_fill_line_addr == i_req.addr[`LSU_ADDR_WIDTH-1:`LSU_OFFSET_WIDTH]);
        o_req    <= i_req;
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush; // killed on flush.
        end
    end

endmodule

/* source/lsu_pkg.sv */
`include "lsu_defs.svh"

package lsu_pkg;

    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_func_t;

    typedef struct packed {
        lsu_func_t                  func;
        logic [`LSU_TAG_WIDTH-1:0]  tag;
        logic [`LSU_ADDR_WIDTH-1:0] addr;
        logic [`LSU_DATA_WIDTH-1:0] data; // store data, unused by loads.
    } lsu_req_t;

    typedef enum logic [1:0] {
        ST_HIT         = 2'd0,
        ST_MISS        = 2'd1,
        ST_FILL_REPLAY = 2'd2
    } lsu_status_t;

    typedef struct packed {
        logic [`LSU_TAG_WIDTH-1:0]  tag;
        lsu_status_t                status;
        logic [`LSU_DATA_WIDTH-1:0] data;
    } lsu_resp_t;

    // whole line moving between memory, the fill unit and the array
    typedef struct packed {
        logic [`LSU_LINE_ADDR_WIDTH-1:0] line_addr;
        logic [`LSU_LINE_WIDTH-1:0]      data;
    } lsu_fill_t;

    typedef struct packed {
        logic [`LSU_ADDR_WIDTH-1:0] addr;
        logic [`LSU_DATA_WIDTH-1:0] data;
    } lsu_store_t;

endpackage

/* source/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

`define LSU_ADDR_WIDTH   32 // byte address.
`define LSU_DATA_WIDTH   32 // one aligned word.
`define LSU_TAG_WIDTH    5  // request tag.
`define LSU_OFFSET_WIDTH 5  // 32 byte line of 8 words.
`define LSU_INDEX_WIDTH  4  // 16 sets.
`define LSU_LINE_WIDTH   256

// derived geometry
`define LSU_LINE_ADDR_WIDTH (`LSU_ADDR_WIDTH - `LSU_OFFSET_WIDTH)
`define LSU_CTAG_WIDTH      (`LSU_LINE_ADDR_WIDTH - `LSU_INDEX_WIDTH)
`define LSU_WORD_SEL_WIDTH  (`LSU_OFFSET_WIDTH - 2) // word within line.

`endif
